// ==== hdl/field_sensor_cfg.svh ====
// Field sensor core configuration
// Fixed widths, filter tap shifts, wavelet depth and Manchester bit timing
// shared by every block of the core

`ifndef FIELD_SENSOR_CFG_SVH
`define FIELD_SENSOR_CFG_SVH

// Front end and artifact filter
`define FS_ADC_BITS     4
`define FS_FILT_TAPS    8
`define FS_FILT_WIDTH   8

// Per-tap right shifts, symmetric window
`define FS_TAP_SHIFT_0  3'd1
`define FS_TAP_SHIFT_1  3'd2
`define FS_TAP_SHIFT_2  3'd3
`define FS_TAP_SHIFT_3  3'd4
`define FS_TAP_SHIFT_4  3'd4
`define FS_TAP_SHIFT_5  3'd3
`define FS_TAP_SHIFT_6  3'd2
`define FS_TAP_SHIFT_7  3'd1

// Wavelet split and band classifier
`define FS_DWT_LEVELS   3
`define FS_SUB_WIDTH    12
`define FS_NUM_BANDS    8
`define FS_POWER_WIDTH  16
`define FS_POWER_SHIFT  2
`define FS_CMD_WIDTH    3

// Clock cycles per Manchester bit, must be even
`define FS_BIT_PERIOD   8

`endif

// ==== hdl/field_sensor_pkg.sv ====
// Field sensor shared types
// Sequencer state encoding plus the sub-band and command data types
// passed between the processing stages

`include "field_sensor_cfg.svh"

package field_sensor_pkg;

    // One pass through the chain, wake to sleep
    typedef enum logic [2:0] {
        IDLE,
        FILTER,
        DECOMPOSE,
        CLASSIFY,
        TRANSMIT,
        SLEEP
    } seq_state_e;

    // Unsigned wavelet coefficient
    typedef logic [`FS_SUB_WIDTH-1:0] sub_band_t;

    // Full set of sub-bands, band 0 is the final approximation
    typedef sub_band_t band_set_t [`FS_NUM_BANDS];

    // Dominant band index sent over LSK
    typedef logic [`FS_CMD_WIDTH-1:0] cmd_t;

endpackage

// ==== hdl/artifact_filter.sv ====
// Artifact filter
// Holds the last eight ADC samples and forms a shift-add weighted sum,
// one tap per cycle, when started. Done pulses 9 cycles after start.

`include "field_sensor_cfg.svh"

module artifact_filter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`FS_ADC_BITS-1:0]   adc_data,
    input  logic                      adc_valid,
    input  logic                      start,
    output logic [`FS_FILT_WIDTH-1:0] filt_out,
    output logic                      done,
    output logic                      busy
);

    logic [`FS_FILT_WIDTH-1:0]        delay_line [`FS_FILT_TAPS];
    logic [$clog2(`FS_FILT_TAPS)-1:0] tap_cnt;
    logic [2:0]                       tap_shift;
    logic [`FS_FILT_WIDTH-1:0]        tap_term;
    logic [`FS_FILT_WIDTH-1:0]        acc;
    logic                             last_tap;

    // Weight of the tap under the counter
    always_comb begin
        case (tap_cnt)
            3'd0:    tap_shift = `FS_TAP_SHIFT_0;
            3'd1:    tap_shift = `FS_TAP_SHIFT_1;
            3'd2:    tap_shift = `FS_TAP_SHIFT_2;
            3'd3:    tap_shift = `FS_TAP_SHIFT_3;
            3'd4:    tap_shift = `FS_TAP_SHIFT_4;
            3'd5:    tap_shift = `FS_TAP_SHIFT_5;
            3'd6:    tap_shift = `FS_TAP_SHIFT_6;
            default: tap_shift = `FS_TAP_SHIFT_7;
        endcase
    end

    assign tap_term = delay_line[tap_cnt] >> tap_shift;
    assign last_tap = (tap_cnt == `FS_FILT_TAPS - 1);

    // Sample history, frozen while a sum is in progress
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `FS_FILT_TAPS; i++) begin
                delay_line[i] <= '0;
            end
        end else if (adc_valid && !busy) begin
            delay_line[0] <= {{(`FS_FILT_WIDTH - `FS_ADC_BITS){1'b0}}, adc_data};
            for (int i = 1; i < `FS_FILT_TAPS; i++) begin
                delay_line[i] <= delay_line[i-1];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            tap_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                tap_cnt <= tap_cnt + 1'b1;
                if (last_tap) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end else if (start) begin
                busy    <= 1'b1;
                tap_cnt <= '0;
            end
        end
    end

    // Running sum, truncated to the output width
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            acc <= '0;
        end else if (busy) begin
            acc <= acc + tap_term;
            if (last_tap) begin
                filt_out <= acc + tap_term;
            end
        end
    end

endmodule

// ==== hdl/wavelet_decomposer.sv ====
// Wavelet decomposer
// Three-level lifting split of the filter result into eight sub-bands,
// one level per cycle. Done pulses 4 cycles after start.

`include "field_sensor_cfg.svh"

module wavelet_decomposer (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`FS_FILT_WIDTH-1:0] filt_in,
    input  logic                      start,
    output logic [`FS_SUB_WIDTH-1:0]  bands [`FS_NUM_BANDS],
    output logic                      done,
    output logic                      busy
);

    import field_sensor_pkg::*;

    sub_band_t                         approx;
    sub_band_t                         approx_half;
    sub_band_t                         detail;
    logic [$clog2(`FS_DWT_LEVELS)-1:0] level;
    logic                              last_level;

    // Lifting step: predict from the halved approximation
    assign approx_half = approx >> 1;
    assign detail      = approx - approx_half;
    assign last_level  = (level == `FS_DWT_LEVELS - 1);

    // ==================================================
    // Level control
    // ==================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            level <= '0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                level <= level + 1'b1;
                if (last_level) begin
                    busy  <= 1'b0;
                    done  <= 1'b1;
                    level <= '0;
                end
            end else if (start) begin
                busy  <= 1'b1;
                level <= '0;
            end
        end
    end

    // ==================================================
    // Coefficient datapath
    // ==================================================
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            approx <= sub_band_t'(filt_in);
        end else if (busy) begin
            approx <= approx_half;
            // Details of levels 1..3 land in bands 1..3
            bands[level + 1'b1] <= detail;
            if (last_level) begin
                bands[0] <= approx_half;
                // Scaled copies
                bands[4] <= bands[1] >> 1;
                bands[5] <= bands[2] >> 1;
                bands[6] <= detail >> 1;
                bands[7] <= approx_half >> 2;
            end
        end
    end

endmodule

// ==== hdl/band_classifier.sv ====
// Band classifier
// Squares the sub-bands one per cycle through a single multiplier and
// keeps the strongest. Its index becomes the command 9 cycles after start.

`include "field_sensor_cfg.svh"

module band_classifier (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`FS_SUB_WIDTH-1:0] bands [`FS_NUM_BANDS],
    input  logic                     start,
    output logic [`FS_CMD_WIDTH-1:0] cmd,
    output logic                     done,
    output logic                     busy
);

    import field_sensor_pkg::*;

    cmd_t                        idx;
    cmd_t                        max_idx;
    logic [2*`FS_SUB_WIDTH-1:0]  square;
    logic [`FS_POWER_WIDTH-1:0]  power;
    logic [`FS_POWER_WIDTH-1:0]  max_pwr;
    logic                        is_larger;
    logic                        last_band;

    // Shared squarer, scaled and cut to the power width
    assign square    = bands[idx] * bands[idx];
    assign power     = square[`FS_POWER_SHIFT +: `FS_POWER_WIDTH];

    // Strict compare so the lowest index keeps a tie
    assign is_larger = (power > max_pwr);
    assign last_band = (idx == `FS_NUM_BANDS - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            idx     <= '0;
            max_idx <= '0;
            max_pwr <= '0;
            cmd     <= '0;
        end else begin
            done <= 1'b0;
            if (busy) begin
                idx <= idx + 1'b1;
                if (is_larger) begin
                    max_pwr <= power;
                    max_idx <= idx;
                end
                if (last_band) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    // Command updates only together with done
                    cmd  <= is_larger ? idx : max_idx;
                end
            end else if (start) begin
                busy    <= 1'b1;
                idx     <= '0;
                max_idx <= '0;
                max_pwr <= '0;
            end
        end
    end

endmodule

// ==== hdl/lsk_modulator.sv ====
// LSK modulator
// Sends the command LSB first as Manchester code on the load switch:
// bit value in the first half period, its inverse in the second

`include "field_sensor_cfg.svh"

module lsk_modulator (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`FS_CMD_WIDTH-1:0] cmd,
    input  logic                     start,
    output logic                     lsk_ctrl,
    output logic                     tx_active
);

    import field_sensor_pkg::*;

    cmd_t                                  shift_reg;
    logic [$clog2(`FS_CMD_WIDTH)-1:0]      bit_cnt;
    logic [$clog2(`FS_BIT_PERIOD/2)-1:0]   half_timer;
    logic                                  second_half;
    logic                                  half_end;

    assign half_end = (half_timer == `FS_BIT_PERIOD/2 - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lsk_ctrl    <= 1'b0;
            tx_active   <= 1'b0;
            shift_reg   <= '0;
            bit_cnt     <= '0;
            half_timer  <= '0;
            second_half <= 1'b0;
        end else if (tx_active) begin
            if (!half_end) begin
                half_timer <= half_timer + 1'b1;
            end else begin
                half_timer <= '0;
                if (!second_half) begin
                    // Mid-bit transition
                    second_half <= 1'b1;
                    lsk_ctrl    <= ~shift_reg[0];
                end else if (bit_cnt == `FS_CMD_WIDTH - 1) begin
                    second_half <= 1'b0;
                    tx_active   <= 1'b0;
                    lsk_ctrl    <= 1'b0;
                end else begin
                    second_half <= 1'b0;
                    bit_cnt     <= bit_cnt + 1'b1;
                    shift_reg   <= shift_reg >> 1;
                    lsk_ctrl    <= shift_reg[1];
                end
            end
        end else if (start) begin
            // First half-bit goes out with tx_active
            tx_active   <= 1'b1;
            lsk_ctrl    <= cmd[0];
            shift_reg   <= cmd;
            bit_cnt     <= '0;
            half_timer  <= '0;
            second_half <= 1'b0;
        end
    end

endmodule

// ==== hdl/event_sequencer.sv ====
// Event sequencer
// Wake-driven FSM that walks the core through filter, wavelet split,
// classification and transmission, then sleeps one cycle.
// Also drives the power gate of the processing stages.

`include "field_sensor_cfg.svh"

module event_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic wake,
    input  logic filt_done,
    input  logic dwt_done,
    input  logic cls_done,
    input  logic tx_active,
    output logic filt_start,
    output logic dwt_start,
    output logic cls_start,
    output logic tx_start,
    output logic pwr_gate_ctrl
);

    import field_sensor_pkg::*;

    seq_state_e state;
    logic       tx_active_q;
    logic       tx_fall;

    // End of transmission
    assign tx_fall = tx_active_q && !tx_active;

    // Stages powered for the whole pass
    assign pwr_gate_ctrl = (state != IDLE) && (state != SLEEP);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= IDLE;
            tx_active_q <= 1'b0;
            filt_start  <= 1'b0;
            dwt_start   <= 1'b0;
            cls_start   <= 1'b0;
            tx_start    <= 1'b0;
        end else begin
            tx_active_q <= tx_active;
            filt_start  <= 1'b0;
            dwt_start   <= 1'b0;
            cls_start   <= 1'b0;
            tx_start    <= 1'b0;

            // Start pulses rise with the entry into their state
            case (state)
                IDLE: begin
                    if (wake) begin
                        state      <= FILTER;
                        filt_start <= 1'b1;
                    end
                end
                FILTER: begin
                    if (filt_done) begin
                        state     <= DECOMPOSE;
                        dwt_start <= 1'b1;
                    end
                end
                DECOMPOSE: begin
                    if (dwt_done) begin
                        state     <= CLASSIFY;
                        cls_start <= 1'b1;
                    end
                end
                CLASSIFY: begin
                    if (cls_done) begin
                        state    <= TRANSMIT;
                        tx_start <= 1'b1;
                    end
                end
                TRANSMIT: begin
                    if (tx_fall) begin
                        state <= SLEEP;
                    end
                end
                SLEEP:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

// ==== hdl/field_sensor_top.sv ====
// Field sensor digital core
// Filter, wavelet split, band classifier and LSK modulator under
// control of the wake-driven event sequencer

`include "field_sensor_cfg.svh"

module field_sensor_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [`FS_ADC_BITS-1:0]  adc_data,
    input  logic                     adc_valid,
    input  logic                     wake,
    output logic [`FS_CMD_WIDTH-1:0] cmd_out,
    output logic                     cmd_valid,
    output logic                     lsk_ctrl,
    output logic                     lsk_tx,
    output logic                     pwr_gate_ctrl,
    output logic                     processing
);

    import field_sensor_pkg::*;

    logic [`FS_FILT_WIDTH-1:0] filt_data;
    band_set_t                 bands;
    cmd_t                      cmd;

    logic filt_start, filt_done, filt_busy;
    logic dwt_start, dwt_done, dwt_busy;
    logic cls_start, cls_done, cls_busy;
    logic tx_start;

    // ==================================================
    // Processing chain
    // ==================================================
    artifact_filter u_filter (
        .clk       (clk),
        .rst_n     (rst_n),
        .adc_data  (adc_data),
        .adc_valid (adc_valid),
        .start     (filt_start),
        .filt_out  (filt_data),
        .done      (filt_done),
        .busy      (filt_busy)
    );

    wavelet_decomposer u_dwt (
        .clk     (clk),
        .rst_n   (rst_n),
        .filt_in (filt_data),
        .start   (dwt_start),
        .bands   (bands),
        .done    (dwt_done),
        .busy    (dwt_busy)
    );

    band_classifier u_classifier (
        .clk   (clk),
        .rst_n (rst_n),
        .bands (bands),
        .start (cls_start),
        .cmd   (cmd),
        .done  (cls_done),
        .busy  (cls_busy)
    );

    lsk_modulator u_lsk (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (cmd),
        .start     (tx_start),
        .lsk_ctrl  (lsk_ctrl),
        .tx_active (lsk_tx)
    );

    // ==================================================
    // Control
    // ==================================================
    event_sequencer u_seq (
        .clk           (clk),
        .rst_n         (rst_n),
        .wake          (wake),
        .filt_done     (filt_done),
        .dwt_done      (dwt_done),
        .cls_done      (cls_done),
        .tx_active     (lsk_tx),
        .filt_start    (filt_start),
        .dwt_start     (dwt_start),
        .cls_start     (cls_start),
        .tx_start      (tx_start),
        .pwr_gate_ctrl (pwr_gate_ctrl)
    );

    assign cmd_out    = cmd;
    assign cmd_valid  = cls_done;
    assign processing = filt_busy | dwt_busy | cls_busy;

endmodule

// ==== dv/field_sensor_tb.sv ====
// Field sensor core testbench
// Reads one wake event per stimulus record, feeds the ADC samples, pulses
// wake and checks the command, the command pulse, the power gate, the
// busy behavior and the Manchester waveform on the LSK switch

`include "field_sensor_cfg.svh"

module field_sensor_tb;

    localparam int MAX_RECORDS = 64;
    localparam int TX_CYCLES   = `FS_CMD_WIDTH * `FS_BIT_PERIOD;

    logic                     clk;
    logic                     rst_n;
    logic [`FS_ADC_BITS-1:0]  adc_data;
    logic                     adc_valid;
    logic                     wake;
    logic [`FS_CMD_WIDTH-1:0] cmd_out;
    logic                     cmd_valid;
    logic                     lsk_ctrl;
    logic                     lsk_tx;
    logic                     pwr_gate_ctrl;
    logic                     processing;

    // Records from the stimulus file
    logic [`FS_ADC_BITS-1:0]  rec_samples [0:MAX_RECORDS-1][0:7];
    logic                     rec_busy    [0:MAX_RECORDS-1];
    logic [`FS_CMD_WIDTH-1:0] rec_cmd     [0:MAX_RECORDS-1];

    int     num_records;
    int     error_count;
    int     pass_count;
    int     fail_count;
    int     cycle_count = 0;
    int     cycle_limit = 0;
    integer seed;

    field_sensor_top u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .adc_data      (adc_data),
        .adc_valid     (adc_valid),
        .wake          (wake),
        .cmd_out       (cmd_out),
        .cmd_valid     (cmd_valid),
        .lsk_ctrl      (lsk_ctrl),
        .lsk_tx        (lsk_tx),
        .pwr_gate_ctrl (pwr_gate_ctrl),
        .processing    (processing)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Run limit scales with the number of records
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the DUT never finished a pass", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    // ==================================================
    // Helpers
    // ==================================================
    task automatic report_mismatch(input string name, input int got, input int exp);
        $display("error at time %0t: %s is %0d, expected %0d", $time, name, got, exp);
        error_count++;
    endtask

    task automatic end_test(input string label, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("%s: pass", label);
        end else begin
            fail_count++;
            $display("%s: FAIL with %0d errors", label, error_count - errors_before);
        end
    endtask

    task automatic load_records();
        integer         fd;
        integer         code;
        integer         v [0:9];
        logic [2047:0]  line;

        num_records = 0;
        fd = $fopen("dv/field_sensor_stim.txt", "r");
        if (fd == 0) begin
            $display("stimulus file dv/field_sensor_stim.txt could not be opened");
            error_count++;
        end else begin
            while (!$feof(fd) && num_records < MAX_RECORDS) begin
                code = $fgets(line, fd);
                if (code != 0) begin
                    // Comment and blank lines do not match
                    code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", v[0], v[1],
                                   v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9]);
                    if (code == 10) begin
                        for (int k = 0; k < 8; k++) begin
                            rec_samples[num_records][k] = v[k];
                        end
                        rec_busy[num_records] = (v[8] != 0);
                        rec_cmd[num_records]  = v[9];
                        num_records++;
                    end
                end
            end
            $fclose(fd);
            if (num_records == 0) begin
                $display("stimulus file holds no records");
                error_count++;
            end
        end
    endtask

    // Oldest sample goes in first while the filter is idle
    task automatic feed_samples(input int idx);
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            adc_data  = rec_samples[idx][k];
            adc_valid = 1'b1;
        end
        @(negedge clk);
        adc_valid = 1'b0;
        adc_data  = '0;
    endtask

    // ==================================================
    // One wake event from wake to the return to idle
    // ==================================================
    task automatic run_pass(input int idx);
        logic [`FS_CMD_WIDTH-1:0] exp_cmd;
        logic                     exp_ctrl;
        int                       valid_seen;
        int                       extra_left;
        int                       tx_pos;
        int                       settle;
        bit                       tx_seen;
        bit                       tx_over;
        bit                       proc_seen;

        exp_cmd    = rec_cmd[idx];
        valid_seen = 0;
        extra_left = rec_busy[idx] ? 4 : 0;
        tx_pos     = 0;
        tx_seen    = 1'b0;
        tx_over    = 1'b0;
        proc_seen  = 1'b0;

        @(negedge clk);
        wake = 1'b1;
        while (!tx_over) begin
            @(negedge clk);
            wake      = 1'b0;
            adc_valid = 1'b0;
            if (cmd_valid === 1'b1) begin
                valid_seen++;
                if (cmd_out !== exp_cmd) report_mismatch("cmd_out", cmd_out, exp_cmd);
            end
            if (processing === 1'b1) proc_seen = 1'b1;
            if (lsk_tx === 1'b1) tx_seen = 1'b1;
            if (tx_seen) begin
                if (tx_pos < TX_CYCLES) begin
                    // Bit value first then its inverse
                    exp_ctrl = exp_cmd[tx_pos / `FS_BIT_PERIOD]
                             ^ ((tx_pos % `FS_BIT_PERIOD) >= `FS_BIT_PERIOD / 2);
                    if (lsk_tx !== 1'b1) report_mismatch("lsk_tx", lsk_tx, 1);
                    if (lsk_ctrl !== exp_ctrl) report_mismatch("lsk_ctrl", lsk_ctrl, exp_ctrl);
                    // All stages have finished before the transmission
                    if (processing !== 1'b0) report_mismatch("processing", processing, 0);
                    tx_pos++;
                end else begin
                    if (lsk_tx !== 1'b0) report_mismatch("lsk_tx", lsk_tx, 0);
                    if (lsk_ctrl !== 1'b0) report_mismatch("lsk_ctrl", lsk_ctrl, 0);
                    tx_over = 1'b1;
                end
            end
            if (!tx_over && pwr_gate_ctrl !== 1'b1) begin
                report_mismatch("pwr_gate_ctrl", pwr_gate_ctrl, 1);
            end
            // Second wake and stray samples while the filter runs
            if (processing === 1'b1 && extra_left > 0) begin
                wake      = 1'b1;
                adc_valid = 1'b1;
                adc_data  = '1;
                extra_left--;
            end
        end

        if (!proc_seen) begin
            $display("record %0d: processing never went high during the pass", idx);
            error_count++;
        end

        settle = 0;
        while ((pwr_gate_ctrl !== 1'b0 || processing !== 1'b0) && settle < 4) begin
            @(negedge clk);
            if (cmd_valid === 1'b1) valid_seen++;
            settle++;
        end
        if (pwr_gate_ctrl !== 1'b0 || processing !== 1'b0) begin
            $display("record %0d: power gate or processing still high after transmission", idx);
            error_count++;
        end
        if (valid_seen != 1) begin
            $display("record %0d: cmd_valid pulsed %0d times instead of once", idx, valid_seen);
            error_count++;
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        int errors_before;
        int gap;

        rst_n       = 1'b0;
        adc_data    = '0;
        adc_valid   = 1'b0;
        wake        = 1'b0;
        seed        = 97266;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;

        load_records();
        cycle_limit = num_records * (40 + TX_CYCLES + 20);

        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        errors_before = error_count;
        if (cmd_out !== '0) report_mismatch("cmd_out", cmd_out, 0);
        if (cmd_valid !== 1'b0) report_mismatch("cmd_valid", cmd_valid, 0);
        if (lsk_ctrl !== 1'b0) report_mismatch("lsk_ctrl", lsk_ctrl, 0);
        if (lsk_tx !== 1'b0) report_mismatch("lsk_tx", lsk_tx, 0);
        if (pwr_gate_ctrl !== 1'b0) report_mismatch("pwr_gate_ctrl", pwr_gate_ctrl, 0);
        if (processing !== 1'b0) report_mismatch("processing", processing, 0);
        end_test("reset state", errors_before);

        for (int r = 0; r < num_records; r++) begin
            errors_before = error_count;
            feed_samples(r);
            gap = {$random(seed)} % 6;
            repeat (gap) @(negedge clk);
            run_pass(r);
            end_test($sformatf("record %0d, command %0d", r, rec_cmd[r]), errors_before);
        end

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 pass_count, fail_count, error_count);
        if (error_count == 0 && fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/field_sensor_pkg.sv
hdl/artifact_filter.sv
hdl/wavelet_decomposer.sv
hdl/band_classifier.sv
hdl/lsk_modulator.sv
hdl/event_sequencer.sv
hdl/field_sensor_top.sv
dv/field_sensor_tb.sv

// ==== Bender.yml ====
package:
  name: field_sensor

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/field_sensor_pkg.sv
      - hdl/artifact_filter.sv
      - hdl/wavelet_decomposer.sv
      - hdl/band_classifier.sv
      - hdl/lsk_modulator.sv
      - hdl/event_sequencer.sv
      - hdl/field_sensor_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/field_sensor_tb.sv

// ==== dv/field_sensor_stim.txt ====
# One wake event per line, all fields hex
# s0..s7 ADC samples oldest first, extra wake flag, expected command
0 0 0 0 0 0 0 0  0  0
F F F F F F F F  1  1
1 1 1 1 1 1 1 1  0  0
2 0 0 0 0 0 0 0  0  0
4 0 0 0 0 0 0 2  0  1
0 3 0 F F 0 3 0  1  0
2 0 0 0 0 0 0 2  0  0
0 4 0 0 0 0 0 0  0  0
0 4 8 0 0 0 0 0  0  0
0 4 8 0 0 8 4 0  0  1
3 5 7 9 B D F 1  0  1
1 2 3 F F 7 3 1  1  0
6 0 0 0 0 0 0 0  0  1
5 0 0 0 0 0 0 0  1  0
C 0 0 0 0 0 0 0  0  1
